/* Makefile */
# Verilator build and run of the decode stage testbench

TOP := tb_decoder

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# the run keeps going after an assertion error so the testbench can end it
test:
	verilator --binary --assert --timing --top-module $(TOP) -f verilog.f -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000

clean:
	rm -rf obj_dir

/* alu_op_decoder.sv */
// OP, OP_IMM, LUI and AUIPC group decoder
`timescale 1ns/100ps
`include "decoder_defines.svh"

module alu_op_decoder (
    input  decoder_pkg::instr_t instr_i,  // raw instruction word
    decode_ctrl_if.decoder_mp   ctrl      // this group's bundle
);
    import decoder_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = instr_i[`OPCODE_RANGE];
    assign funct3 = instr_i[`FUNCT3_RANGE];
    assign funct7 = instr_i[`FUNCT7_RANGE];

    // funct3 map shared by register and immediate forms
    function automatic alu_operation_t base_op(input funct3_t f3);
        alu_operation_t op;
        case (f3)
            3'b000:  op = ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl.hit             = 1'b0;  // idle bundle
        ctrl.alu_operation   = ALU_ADD;
        ctrl.alu_source_1    = ALU_SCR1_RS1;
        ctrl.alu_source_2    = ALU_SCR2_RS2;
        ctrl.immediate_type  = IMM_I;
        ctrl.mem_wen         = 1'b0;
        ctrl.mem_data_type   = WORD;
        ctrl.mem_sign_extend = 1'b0;
        ctrl.reg_alu_wen     = 1'b0;
        ctrl.reg_mem_wen     = 1'b0;
        ctrl.pc_source       = PC_NEXT;
        ctrl.is_branch       = 1'b0;
        ctrl.illegal         = 1'b0;

        case (opcode)
            //////////////////////////////////////////////////
            // register-register
            `OPCODE_OP: begin
                ctrl.hit         = 1'b1;
                ctrl.reg_alu_wen = 1'b1;
                if (funct7 == `FUNCT7_BASE) begin
                    ctrl.alu_operation = base_op(funct3);
                end else if (funct7 == `FUNCT7_ALT) begin
                    case (funct3)
                        3'b000:  ctrl.alu_operation = ALU_SUB;
                        3'b101:  ctrl.alu_operation = ALU_SRA;
                        default: ctrl.illegal = 1'b1;  // no alt form
                    endcase
                end else begin
                    ctrl.illegal = 1'b1;  // reserved funct7
                end
            end
            //////////////////////////////////////////////////
            // register-immediate
            `OPCODE_OP_IMM: begin
                ctrl.hit            = 1'b1;
                ctrl.reg_alu_wen    = 1'b1;
                ctrl.alu_source_2   = ALU_SCR2_IMM;
                ctrl.immediate_type = IMM_I;
                ctrl.alu_operation  = base_op(funct3);
                if (funct3 == 3'b001 && funct7 != `FUNCT7_BASE) begin
                    ctrl.illegal = 1'b1;  // slli needs base funct7
                end else if (funct3 == 3'b101) begin
                    if (funct7 == `FUNCT7_ALT)
                        ctrl.alu_operation = ALU_SRA;  // srai
                    else if (funct7 != `FUNCT7_BASE)
                        ctrl.illegal = 1'b1;
                end
            end
            `OPCODE_LUI, `OPCODE_AUIPC: begin
                ctrl.hit            = 1'b1;
                ctrl.reg_alu_wen    = 1'b1;
                ctrl.alu_source_2   = ALU_SCR2_IMM;
                ctrl.immediate_type = IMM_U;
                // lui adds to zero, auipc to pc
                ctrl.alu_source_1   = (opcode == `OPCODE_LUI) ? ALU_SCR1_ZERO : ALU_SCR1_PC;
            end
            default: ;  // other groups
        endcase
    end

endmodule

/* decode_ctrl_if.sv */
// control bundle of one opcode-group decoder, driver and merge modports
`timescale 1ns/100ps

interface decode_ctrl_if;
    import decoder_pkg::*;

    logic              hit;             // opcode belongs to this group
    alu_operation_t    alu_operation;
    alu_source_1_t     alu_source_1;
    alu_source_2_t     alu_source_2;
    immediate_source_t immediate_type;
    logic              mem_wen;
    data_type_t        mem_data_type;
    logic              mem_sign_extend;
    logic              reg_alu_wen;
    logic              reg_mem_wen;
    pc_source_t        pc_source;
    logic              is_branch;
    logic              illegal;         // group rejects encoding

    modport decoder_mp (
        output hit, alu_operation, alu_source_1, alu_source_2, immediate_type,
               mem_wen, mem_data_type, mem_sign_extend, reg_alu_wen, reg_mem_wen,
               pc_source, is_branch, illegal
    );

    modport merge_mp (
        input hit, alu_operation, alu_source_1, alu_source_2, immediate_type,
              mem_wen, mem_data_type, mem_sign_extend, reg_alu_wen, reg_mem_wen,
              pc_source, is_branch, illegal
    );

endinterface

/* decode_result_reg.sv */
// group bundle merge, unknown-opcode flag and strobe-qualified output register
`timescale 1ns/100ps
`include "decoder_defines.svh"

module decode_result_reg (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          instr_valid_i,
    input  decoder_pkg::instr_t           instr_i,
    decode_ctrl_if.merge_mp               alu_bus,
    decode_ctrl_if.merge_mp               mem_bus,
    decode_ctrl_if.merge_mp               flow_bus,
    output logic                          ctrl_valid_o,      // one cycle after strobe
    output decoder_pkg::alu_operation_t    alu_operation_o,
    output decoder_pkg::alu_source_1_t     alu_source_1_o,
    output decoder_pkg::alu_source_2_t     alu_source_2_o,
    output decoder_pkg::immediate_source_t immediate_type_o,
    output decoder_pkg::reg_addr_t         rs1_addr_o,
    output decoder_pkg::reg_addr_t         rs2_addr_o,
    output decoder_pkg::reg_addr_t         rd_addr_o,
    output logic                          mem_wen_o,
    output decoder_pkg::data_type_t        mem_data_type_o,
    output logic                          mem_sign_extend_o,
    output logic                          reg_alu_wen_o,
    output logic                          reg_mem_wen_o,
    output decoder_pkg::pc_source_t        pc_source_o,
    output logic                          is_branch_o,
    output logic                          illegal_instr_o
);
    import decoder_pkg::*;

    logic any_hit;  // some group claimed the opcode

    assign any_hit = alu_bus.hit | mem_bus.hit | flow_bus.hit;

    //////////////////////////////////////////////////
    // payload, loaded on strobe only
    // idle bundles are all zero so OR selects the hit one
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            alu_operation_o   <= alu_operation_t'(alu_bus.alu_operation
                                 | mem_bus.alu_operation | flow_bus.alu_operation);
            alu_source_1_o    <= alu_source_1_t'(alu_bus.alu_source_1
                                 | mem_bus.alu_source_1 | flow_bus.alu_source_1);
            alu_source_2_o    <= alu_source_2_t'(alu_bus.alu_source_2
                                 | mem_bus.alu_source_2 | flow_bus.alu_source_2);
            immediate_type_o  <= immediate_source_t'(alu_bus.immediate_type
                                 | mem_bus.immediate_type | flow_bus.immediate_type);
            mem_data_type_o   <= data_type_t'(alu_bus.mem_data_type
                                 | mem_bus.mem_data_type | flow_bus.mem_data_type);
            mem_sign_extend_o <= alu_bus.mem_sign_extend | mem_bus.mem_sign_extend
                                 | flow_bus.mem_sign_extend;
            rs1_addr_o        <= instr_i[`RS1_RANGE];
            rs2_addr_o        <= instr_i[`RS2_RANGE];
            rd_addr_o         <= instr_i[`RD_RANGE];
        end
    end

    //////////////////////////////////////////////////
    // control state, cleared by reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_valid_o    <= 1'b0;
            mem_wen_o       <= 1'b0;
            reg_alu_wen_o   <= 1'b0;
            reg_mem_wen_o   <= 1'b0;
            pc_source_o     <= PC_NEXT;
            is_branch_o     <= 1'b0;
            illegal_instr_o <= 1'b0;
        end else begin
            ctrl_valid_o <= instr_valid_i;  // single pulse per strobe
            if (instr_valid_i) begin
                mem_wen_o       <= alu_bus.mem_wen | mem_bus.mem_wen | flow_bus.mem_wen;
                reg_alu_wen_o   <= alu_bus.reg_alu_wen | mem_bus.reg_alu_wen
                                   | flow_bus.reg_alu_wen;
                reg_mem_wen_o   <= alu_bus.reg_mem_wen | mem_bus.reg_mem_wen
                                   | flow_bus.reg_mem_wen;
                pc_source_o     <= pc_source_t'(alu_bus.pc_source | mem_bus.pc_source
                                   | flow_bus.pc_source);
                is_branch_o     <= alu_bus.is_branch | mem_bus.is_branch | flow_bus.is_branch;
                // system and unknown opcodes fall through as illegal
                illegal_instr_o <= !any_hit | alu_bus.illegal | mem_bus.illegal
                                   | flow_bus.illegal;
            end
        end
    end

endmodule

/* decoder_checker.sv */
// concurrent assertions holding the decode rules, bound into decoder_top
`timescale 1ns/100ps
`include "decoder_defines.svh"

module decoder_checker (
    input logic                           clk_i,
    input logic                           rst_n_i,
    input logic                           instr_valid_i,
    input decoder_pkg::instr_t            instr_i,
    input logic                           ctrl_valid_o,
    input decoder_pkg::alu_operation_t    alu_operation_o,
    input decoder_pkg::alu_source_1_t     alu_source_1_o,
    input decoder_pkg::alu_source_2_t     alu_source_2_o,
    input decoder_pkg::immediate_source_t immediate_type_o,
    input decoder_pkg::reg_addr_t         rs1_addr_o,
    input decoder_pkg::reg_addr_t         rs2_addr_o,
    input decoder_pkg::reg_addr_t         rd_addr_o,
    input logic                           mem_wen_o,
    input decoder_pkg::data_type_t        mem_data_type_o,
    input logic                           mem_sign_extend_o,
    input logic                           reg_alu_wen_o,
    input logic                           reg_mem_wen_o,
    input decoder_pkg::pc_source_t        pc_source_o,
    input logic                           is_branch_o,
    input logic                           illegal_instr_o
);
    import decoder_pkg::*;

    // lookup tables indexed by funct3
    localparam alu_operation_t ALU_BY_F3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                                ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    localparam alu_operation_t CMP_BY_F3 [8] = '{ALU_SEQ, ALU_SNE, ALU_ADD, ALU_ADD,
                                                ALU_SLT, ALU_SGE, ALU_SLTU, ALU_SGEU};
    localparam data_type_t SIZE_BY_F3 [4] = '{BYTE, HALF_WORD, WORD, WORD};

    bit                failed = 1'b0;  // polled from the testbench
    logic              seen_strobe;    // some decode loaded since reset
    instr_t            held;           // last strobed word
    opcode_t           op;
    funct3_t           f3;
    funct7_t           f7;
    alu_operation_t    exp_op;
    alu_source_1_t     exp_src1;
    alu_source_2_t     exp_src2;
    immediate_source_t exp_imm;
    data_type_t        exp_dtype;
    logic              exp_sign;
    logic [2:0]        exp_wen;        // {reg_alu, reg_mem, mem}
    pc_source_t        exp_pc;
    logic              exp_illegal;

    assign op = held[`OPCODE_RANGE];
    assign f3 = held[`FUNCT3_RANGE];
    assign f7 = held[`FUNCT7_RANGE];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            seen_strobe <= 1'b0;
        end else if (instr_valid_i) begin
            seen_strobe <= 1'b1;
            held        <= instr_i;
        end
    end

    //////////////////////////////////////////////////
    // reference decode of the held word
    always_comb begin
        exp_op      = ALU_ADD;
        exp_src1    = ALU_SCR1_RS1;
        exp_src2    = ALU_SCR2_RS2;
        exp_imm     = IMM_I;
        exp_dtype   = WORD;
        exp_sign    = 1'b0;
        exp_wen     = 3'b000;
        exp_pc      = PC_NEXT;
        exp_illegal = 1'b0;
        case (op)
            `OPCODE_OP: begin
                exp_wen     = 3'b100;
                exp_op      = ALU_BY_F3[f3];
                exp_illegal = !(f7 == `FUNCT7_BASE
                                || (f7 == `FUNCT7_ALT && f3 inside {3'd0, 3'd5}));
                if (f7 == `FUNCT7_ALT)
                    exp_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
            end
            `OPCODE_OP_IMM: begin
                exp_wen     = 3'b100;
                exp_src2    = ALU_SCR2_IMM;
                exp_op      = ALU_BY_F3[f3];
                exp_illegal = (f3 == 3'd1 && f7 != `FUNCT7_BASE)
                              || (f3 == 3'd5 && !(f7 inside {`FUNCT7_BASE, `FUNCT7_ALT}));
                if (f3 == 3'd5 && f7 == `FUNCT7_ALT)
                    exp_op = ALU_SRA;  // srai
            end
            `OPCODE_LUI: begin
                exp_wen  = 3'b100;
                exp_src1 = ALU_SCR1_ZERO;
                exp_src2 = ALU_SCR2_IMM;
                exp_imm  = IMM_U;
            end
            `OPCODE_AUIPC: begin
                exp_wen  = 3'b100;
                exp_src1 = ALU_SCR1_PC;
                exp_src2 = ALU_SCR2_IMM;
                exp_imm  = IMM_U;
            end
            `OPCODE_LOAD: begin
                exp_wen     = 3'b010;
                exp_src2    = ALU_SCR2_IMM;
                exp_dtype   = SIZE_BY_F3[f3[1:0]];
                exp_sign    = !f3[2];        // lb lh lw sign extend
                exp_illegal = f3 inside {3'd3, 3'd6, 3'd7};
            end
            `OPCODE_STORE: begin
                exp_wen     = 3'b001;
                exp_src2    = ALU_SCR2_IMM;
                exp_imm     = IMM_S;
                exp_dtype   = SIZE_BY_F3[f3[1:0]];
                exp_illegal = f3 > 3'd2;
            end
            `OPCODE_BRANCH: begin
                exp_imm     = IMM_B;
                exp_pc      = PC_BRANCH;
                exp_op      = CMP_BY_F3[f3];
                exp_illegal = f3 inside {3'd2, 3'd3};
            end
            `OPCODE_JAL, `OPCODE_JALR: begin
                exp_wen  = 3'b100;           // link register
                exp_src1 = ALU_SCR1_PC;
                exp_src2 = ALU_SCR2_PC_INC;
                exp_imm  = (op == `OPCODE_JAL) ? IMM_J : IMM_I;
                exp_pc   = (op == `OPCODE_JAL) ? PC_JAL : PC_JALR;
                exp_illegal = (op == `OPCODE_JALR) && f3 != 3'd0;
            end
            default: exp_illegal = 1'b1;     // system and unused opcodes
        endcase
    end

    //////////////////////////////////////////////////
    // handshake
    a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl_valid_o == $past(instr_valid_i))
        else begin
            failed = 1'b1;
            $error("[FAIL] ctrl_valid_o expected %h got %h",
                   $past(instr_valid_i), $sampled(ctrl_valid_o));
        end

    a_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !seen_strobe |-> !(ctrl_valid_o | mem_wen_o | reg_alu_wen_o | reg_mem_wen_o
                           | is_branch_o | illegal_instr_o) && pc_source_o == PC_NEXT)
        else begin
            failed = 1'b1;
            $error("control outputs not in their reset state before the first strobe");
        end

    //////////////////////////////////////////////////
    // decoded fields, outputs hold between strobes
    a_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        seen_strobe && !exp_illegal |-> alu_operation_o == exp_op)
        else begin
            failed = 1'b1;
            $error("[FAIL] alu_operation_o expected %h got %h",
                   $sampled(exp_op), $sampled(alu_operation_o));
        end

    a_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        seen_strobe |-> {alu_source_1_o, alu_source_2_o, immediate_type_o}
                        == {exp_src1, exp_src2, exp_imm})
        else begin
            failed = 1'b1;
            $error("[FAIL] alu_source_1_o/alu_source_2_o/immediate_type_o expected %h got %h",
                   $sampled({exp_src1, exp_src2, exp_imm}),
                   $sampled({alu_source_1_o, alu_source_2_o, immediate_type_o}));
        end

    a_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        seen_strobe && !exp_illegal |-> {mem_data_type_o, mem_sign_extend_o}
                                        == {exp_dtype, exp_sign})
        else begin
            failed = 1'b1;
            $error("[FAIL] mem_data_type_o/mem_sign_extend_o expected %h got %h",
                   $sampled({exp_dtype, exp_sign}),
                   $sampled({mem_data_type_o, mem_sign_extend_o}));
        end

    a_wen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        seen_strobe |-> {reg_alu_wen_o, reg_mem_wen_o, mem_wen_o} == exp_wen)
        else begin
            failed = 1'b1;
            $error("[FAIL] reg_alu_wen_o/reg_mem_wen_o/mem_wen_o expected %h got %h",
                   $sampled(exp_wen), $sampled({reg_alu_wen_o, reg_mem_wen_o, mem_wen_o}));
        end

    a_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        seen_strobe |-> pc_source_o == exp_pc && is_branch_o == (exp_pc == PC_BRANCH))
        else begin
            failed = 1'b1;
            $error("[FAIL] pc_source_o/is_branch_o expected %h got %h",
                   $sampled({exp_pc, exp_pc == PC_BRANCH}),
                   $sampled({pc_source_o, is_branch_o}));
        end

    a_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        seen_strobe |-> illegal_instr_o == exp_illegal)
        else begin
            failed = 1'b1;
            $error("[FAIL] illegal_instr_o expected %h got %h",
                   $sampled(exp_illegal), $sampled(illegal_instr_o));
        end

    a_regs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl_valid_o |-> {rs1_addr_o, rs2_addr_o, rd_addr_o} == $past({instr_i[`RS1_RANGE],
                         instr_i[`RS2_RANGE], instr_i[`RD_RANGE]}))
        else begin
            failed = 1'b1;
            $error("[FAIL] rs1_addr_o/rs2_addr_o/rd_addr_o expected %h got %h",
                   $past({instr_i[`RS1_RANGE], instr_i[`RS2_RANGE], instr_i[`RD_RANGE]}),
                   $sampled({rs1_addr_o, rs2_addr_o, rd_addr_o}));
        end

endmodule

/* decoder_defines.svh */
// widths, instruction field ranges, major opcodes and funct7 codes of the decode stage
`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

// widths
`define XLEN       32
`define REG_ADDR_W 5
`define OPCODE_W   7
`define FUNCT3_W   3
`define FUNCT7_W   7

// fixed field positions, 32-bit encodings only
`define OPCODE_RANGE 6:0
`define RD_RANGE     11:7
`define FUNCT3_RANGE 14:12
`define RS1_RANGE    19:15
`define RS2_RANGE    24:20
`define FUNCT7_RANGE 31:25

// base integer major opcodes (SYSTEM not decoded here)
`define OPCODE_OP     7'b0110011
`define OPCODE_OP_IMM 7'b0010011
`define OPCODE_LUI    7'b0110111
`define OPCODE_AUIPC  7'b0010111
`define OPCODE_LOAD   7'b0000011
`define OPCODE_STORE  7'b0100011
`define OPCODE_BRANCH 7'b1100011
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111

`define FUNCT7_BASE 7'h00 // add, srl and friends
`define FUNCT7_ALT  7'h20 // sub, sra

`endif

/* decoder_pkg.sv */
// vector typedefs and control enums shared by the decode stage
`include "decoder_defines.svh"

package decoder_pkg;

    // instruction fields
    typedef logic [`XLEN-1:0]       instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`OPCODE_W-1:0]   opcode_t;
    typedef logic [`FUNCT3_W-1:0]   funct3_t;
    typedef logic [`FUNCT7_W-1:0]   funct7_t;

    // idle value of every enum is the all-zero code
    // so unclaimed group bundles drop out of the merge
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU,
        ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU   // branch compares
    } alu_operation_t;

    typedef enum logic [1:0] {
        ALU_SCR1_RS1, ALU_SCR1_PC, ALU_SCR1_ZERO
    } alu_source_1_t;

    typedef enum logic [1:0] {
        ALU_SCR2_RS2, ALU_SCR2_IMM,
        ALU_SCR2_PC_INC   // constant 4 for link address
    } alu_source_2_t;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } immediate_source_t;

    typedef enum logic [1:0] {
        WORD      = 2'b00,  // default access size
        HALF_WORD = 2'b01,
        BYTE      = 2'b10
    } data_type_t;

    typedef enum logic [1:0] {
        PC_NEXT, PC_BRANCH, PC_JAL, PC_JALR
    } pc_source_t;

endpackage

/* decoder_top.sv */
// decode stage top, three group decoders feeding the result register
`timescale 1ns/100ps

module decoder_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          instr_valid_i,     // one-cycle strobe
    input  decoder_pkg::instr_t           instr_i,
    output logic                          ctrl_valid_o,
    output decoder_pkg::alu_operation_t    alu_operation_o,
    output decoder_pkg::alu_source_1_t     alu_source_1_o,
    output decoder_pkg::alu_source_2_t     alu_source_2_o,
    output decoder_pkg::immediate_source_t immediate_type_o,
    output decoder_pkg::reg_addr_t         rs1_addr_o,
    output decoder_pkg::reg_addr_t         rs2_addr_o,
    output decoder_pkg::reg_addr_t         rd_addr_o,
    output logic                          mem_wen_o,
    output decoder_pkg::data_type_t        mem_data_type_o,
    output logic                          mem_sign_extend_o,
    output logic                          reg_alu_wen_o,
    output logic                          reg_mem_wen_o,
    output decoder_pkg::pc_source_t        pc_source_o,
    output logic                          is_branch_o,
    output logic                          illegal_instr_o
);

    // one bundle per opcode group
    decode_ctrl_if alu_bus ();
    decode_ctrl_if mem_bus ();
    decode_ctrl_if flow_bus ();

    alu_op_decoder  u_alu_dec  (.instr_i(instr_i), .ctrl(alu_bus));
    mem_op_decoder  u_mem_dec  (.instr_i(instr_i), .ctrl(mem_bus));
    flow_op_decoder u_flow_dec (.instr_i(instr_i), .ctrl(flow_bus));

    // merge and pipeline register, plain ports by name
    decode_result_reg u_result_reg (
        .alu_bus  (alu_bus),
        .mem_bus  (mem_bus),
        .flow_bus (flow_bus),
        .*
    );

endmodule

/* flow_op_decoder.sv */
// BRANCH, JAL and JALR group decoder
`timescale 1ns/100ps
`include "decoder_defines.svh"

module flow_op_decoder (
    input  decoder_pkg::instr_t instr_i,  // raw instruction word
    decode_ctrl_if.decoder_mp   ctrl      // this group's bundle
);
    import decoder_pkg::*;

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = instr_i[`OPCODE_RANGE];
    assign funct3 = instr_i[`FUNCT3_RANGE];

    always_comb begin
        ctrl.hit             = 1'b0;
        ctrl.alu_operation   = ALU_ADD;
        ctrl.alu_source_1    = ALU_SCR1_RS1;
        ctrl.alu_source_2    = ALU_SCR2_RS2;
        ctrl.immediate_type  = IMM_I;
        ctrl.mem_wen         = 1'b0;
        ctrl.mem_data_type   = WORD;
        ctrl.mem_sign_extend = 1'b0;
        ctrl.reg_alu_wen     = 1'b0;
        ctrl.reg_mem_wen     = 1'b0;
        ctrl.pc_source       = PC_NEXT;
        ctrl.is_branch       = 1'b0;
        ctrl.illegal         = 1'b0;

        case (opcode)
            `OPCODE_BRANCH: begin
                // alu compares, target comes from a separate adder
                ctrl.hit            = 1'b1;
                ctrl.immediate_type = IMM_B;
                ctrl.pc_source      = PC_BRANCH;
                ctrl.is_branch      = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_operation = ALU_SEQ;  // beq
                    3'b001:  ctrl.alu_operation = ALU_SNE;  // bne
                    3'b100:  ctrl.alu_operation = ALU_SLT;  // blt
                    3'b101:  ctrl.alu_operation = ALU_SGE;  // bge
                    3'b110:  ctrl.alu_operation = ALU_SLTU; // bltu
                    3'b111:  ctrl.alu_operation = ALU_SGEU; // bgeu
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `OPCODE_JAL, `OPCODE_JALR: begin
                ctrl.hit          = 1'b1;
                ctrl.alu_source_1 = ALU_SCR1_PC;      // link = pc + 4
                ctrl.alu_source_2 = ALU_SCR2_PC_INC;
                ctrl.reg_alu_wen  = 1'b1;
                if (opcode == `OPCODE_JAL) begin
                    ctrl.immediate_type = IMM_J;
                    ctrl.pc_source      = PC_JAL;
                end else begin
                    ctrl.pc_source = PC_JALR;
                    ctrl.illegal   = (funct3 != 3'b000);
                end
            end
            default: ;
        endcase
    end

endmodule

/* mem_op_decoder.sv */
// LOAD and STORE group decoder
`timescale 1ns/100ps
`include "decoder_defines.svh"

module mem_op_decoder (
    input  decoder_pkg::instr_t instr_i,  // raw instruction word
    decode_ctrl_if.decoder_mp   ctrl      // this group's bundle
);
    import decoder_pkg::*;

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = instr_i[`OPCODE_RANGE];
    assign funct3 = instr_i[`FUNCT3_RANGE];

    always_comb begin
        ctrl.hit             = 1'b0;
        ctrl.alu_operation   = ALU_ADD;        // address = rs1 + imm
        ctrl.alu_source_1    = ALU_SCR1_RS1;
        ctrl.alu_source_2    = ALU_SCR2_RS2;
        ctrl.immediate_type  = IMM_I;
        ctrl.mem_wen         = 1'b0;
        ctrl.mem_data_type   = WORD;
        ctrl.mem_sign_extend = 1'b0;
        ctrl.reg_alu_wen     = 1'b0;
        ctrl.reg_mem_wen     = 1'b0;
        ctrl.pc_source       = PC_NEXT;
        ctrl.is_branch       = 1'b0;
        ctrl.illegal         = 1'b0;

        if (opcode == `OPCODE_LOAD) begin
            ctrl.hit             = 1'b1;
            ctrl.alu_source_2    = ALU_SCR2_IMM;
            ctrl.reg_mem_wen     = 1'b1;
            ctrl.mem_sign_extend = !funct3[2];  // lbu/lhu zero extend
            case (funct3)
                3'b000, 3'b100: ctrl.mem_data_type = BYTE;
                3'b001, 3'b101: ctrl.mem_data_type = HALF_WORD;
                3'b010:         ctrl.mem_data_type = WORD;
                default:        ctrl.illegal = 1'b1;
            endcase
        end else if (opcode == `OPCODE_STORE) begin
            ctrl.hit            = 1'b1;
            ctrl.alu_source_2   = ALU_SCR2_IMM;
            ctrl.immediate_type = IMM_S;
            ctrl.mem_wen        = 1'b1;
            case (funct3)
                3'b000:  ctrl.mem_data_type = BYTE;      // sb
                3'b001:  ctrl.mem_data_type = HALF_WORD; // sh
                3'b010:  ctrl.mem_data_type = WORD;      // sw
                default: ctrl.illegal = 1'b1;
            endcase
        end
    end

endmodule

/* tb_decoder.sv */
// testbench clock, reset, random strobed instruction stream, timeout and end of run
`timescale 1ns/100ps
`include "decoder_defines.svh"

module tb_decoder;
    import decoder_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTR    = 2000;
    // at most one idle cycle follows each strobe
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * NUM_INSTR + 20;

    // nine decoded groups, SYSTEM and one unused opcode
    localparam opcode_t OPCODE_POOL [11] = '{
        `OPCODE_OP, `OPCODE_OP_IMM, `OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_LOAD,
        `OPCODE_STORE, `OPCODE_BRANCH, `OPCODE_JAL, `OPCODE_JALR,
        7'b1110011,   // system
        7'b0001011    // custom-0, never decoded
    };

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              instr_valid_i;
    instr_t            instr_i;
    logic              ctrl_valid_o;
    alu_operation_t    alu_operation_o;
    alu_source_1_t     alu_source_1_o;
    alu_source_2_t     alu_source_2_o;
    immediate_source_t immediate_type_o;
    reg_addr_t         rs1_addr_o;
    reg_addr_t         rs2_addr_o;
    reg_addr_t         rd_addr_o;
    logic              mem_wen_o;
    data_type_t        mem_data_type_o;
    logic              mem_sign_extend_o;
    logic              reg_alu_wen_o;
    logic              reg_mem_wen_o;
    pc_source_t        pc_source_o;
    logic              is_branch_o;
    logic              illegal_instr_o;
    int                cycle_count = 0;

    always #4 clk_i = ~clk_i;  // 8 ns period

    decoder_top uut (.*);

    bind decoder_top decoder_checker chk (.*);

    // random word with the opcode field taken from the pool
    // funct7 leans on its two legal codes so sub, sra and srai come up
    function automatic instr_t make_instr();
        instr_t     word;
        logic [3:0] pick;
        word      = $urandom;
        pick      = 4'($urandom_range(10, 0));
        word[6:0] = OPCODE_POOL[pick];
        case ($urandom_range(3, 0))
            0:       word[31:25] = `FUNCT7_BASE;
            1:       word[31:25] = `FUNCT7_ALT;
            default: ;  // random, mostly reserved
        endcase
        return word;
    endfunction

    //////////////////////////////////////////////////
    // timeout and assertion watch
    always @(negedge clk_i) begin
        cycle_count++;
        if (uut.chk.failed) begin
            $display("Finished with errors");
            $fatal(1, "decode assertion failed at cycle %0d", cycle_count);
        end else if (cycle_count > MAX_CYCLES) begin
            $display("Finished with errors");
            $fatal(1, "timeout, stimulus still running after %0d cycles", MAX_CYCLES);
        end
    end

    //////////////////////////////////////////////////
    // stimulus, driven on the falling edge
    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        void'($urandom(32'h9c32));  // seed once

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        instr_i = $urandom;              // noise ahead of the first strobe
        repeat (4) @(negedge clk_i);

        for (int n = 0; n < NUM_INSTR; n++) begin
            instr_valid_i = 1'b1;
            instr_i       = make_instr();
            @(negedge clk_i);
            instr_valid_i = 1'b0;
            if ($urandom_range(2, 0) != 0) begin  // idle two times in three
                instr_i = $urandom;               // noise, must not load
                @(negedge clk_i);
            end
        end

        repeat (3) @(negedge clk_i);  // let the last decode reach the checker
        if (uut.chk.failed) begin
            $display("Finished with errors");
            $fatal(1, "decode assertion failed near the end of the stimulus");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+.
decoder_pkg.sv
decode_ctrl_if.sv
alu_op_decoder.sv
mem_op_decoder.sv
flow_op_decoder.sv
decode_result_reg.sv
decoder_top.sv
decoder_checker.sv
tb_decoder.sv
